// File: Bender.yml
package:
  name: pad_core

sources:
  - pad_cfg_pkg.sv
  - apb_pkg.sv
  - reset_ctrl.sv
  - gpio_sync.sv
  - pad_regs.sv
  - pad_core.sv
  - target: test
    files:
      - tb_pad_core.sv

// File: apb_pkg.sv
// Zero wait state APB without pprot or pstrb, word aligned byte addresses only
`default_nettype none

package apb_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // --------------------
    // Bus payloads

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // --------------------
    // Register map

    typedef enum logic [ADDR_W-1:0] {
        PAD_DRIVE   = 8'h00,
        PAD_SLEW    = 8'h04,
        PAD_SCHMITT = 8'h08,
        GPIO_OUT    = 8'h0c,
        GPIO_OE     = 8'h10,
        GPIO_PU     = 8'h14,
        GPIO_PD     = 8'h18,
        GPIO_IN     = 8'h1c,    // read only
        GPIO_EDGE   = 8'h20,    // write 1 to clear
        SYS_CTRL    = 8'h24     // bit 0 requests soft reset
    } reg_addr_e;

    // Implemented bits per register, the rest read as 0
    localparam int REG_DRIVE_W   = 2 * pad_cfg_pkg::N_PAD_GROUPS;
    localparam int REG_SLEW_W    = pad_cfg_pkg::N_PAD_GROUPS;
    localparam int REG_SCHMITT_W = pad_cfg_pkg::N_SCHMITT;
    localparam int REG_GPIO_W    = pad_cfg_pkg::N_GPIO;

endpackage

`default_nettype wire

// File: gpio_sync.sv
// Inputs are asynchronous to clk and a pulse shorter than one clock period may be missed
`timescale 1ns/1ps
`default_nettype none

module gpio_sync (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [pad_cfg_pkg::N_GPIO-1:0] padin_gpio,
    input  logic [pad_cfg_pkg::N_GPIO-1:0] edge_clr,
    output logic [pad_cfg_pkg::N_GPIO-1:0] gpio_level,
    output logic [pad_cfg_pkg::N_GPIO-1:0] gpio_edge
);

    import pad_cfg_pkg::*;

    logic [N_GPIO-1:0] meta_q;
    logic [N_GPIO-1:0] level_q;
    logic [N_GPIO-1:0] level_d_q;
    logic [N_GPIO-1:0] rise;
    logic [N_GPIO-1:0] edge_q;

    // --------------------
    // Input synchronizer

    // Two flops against metastability and a delayed copy for edge detection
    always_ff @(posedge clk) begin
        meta_q    <= padin_gpio;
        level_q   <= meta_q;
        level_d_q <= level_q;
    end

    assign gpio_level = level_q;
    assign rise       = level_q & ~level_d_q;

    // --------------------
    // Sticky edge capture

    // A new edge beats a clear of the same bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_q <= '0;
        end else begin
            edge_q <= (edge_q & ~edge_clr) | rise;
        end
    end

    assign gpio_edge = edge_q;

endmodule

`default_nettype wire

// File: pad_cfg_pkg.sv
// Group order sets the drive and slew bit packing and only dio, sram_dq and gpio have Schmitt
`default_nettype none

package pad_cfg_pkg;

    // --------------------
    // Pad groups

    // Order matters, it fixes the bit position in the drive and slew fields
    typedef enum logic [3:0] {
        GRP_DIO         = 4'd0,
        GRP_SRAM_DQ     = 4'd1,
        GRP_SRAM_A      = 4'd2,
        GRP_SRAM_STROBE = 4'd3,
        GRP_AUDIO       = 4'd4,
        GRP_LCD_CLK     = 4'd5,
        GRP_LCD_DAT     = 4'd6,
        GRP_LCD_DCCS    = 4'd7,
        GRP_LCD_BL      = 4'd8,
        GRP_GPIO        = 4'd9
    } pad_group_e;

    localparam int N_PAD_GROUPS = int'(GRP_GPIO) + 1;

    // Drive strength, weakest first
    typedef enum logic [1:0] {
        DRIVE_MIN  = 2'd0,
        DRIVE_LOW  = 2'd1,
        DRIVE_HIGH = 2'd2,
        DRIVE_MAX  = 2'd3
    } drive_e;

    localparam int N_GPIO    = 7;
    // Schmitt bits in order dio, sram_dq, gpio
    localparam int N_SCHMITT = 3;

    // --------------------
    // Pad attributes

    typedef struct packed {
        drive_e [N_PAD_GROUPS-1:0] drive;
        logic   [N_PAD_GROUPS-1:0] slew;    // 1 selects slow edges
        logic   [N_SCHMITT-1:0]    schmitt;
        logic   [N_GPIO-1:0]       gpio_pu;
        logic   [N_GPIO-1:0]       gpio_pd;
    } pad_attr_t;

    // Weakest drive, slow slew, Schmitt on, pull-down on all but the top GPIO
    localparam pad_attr_t PAD_ATTR_RESET = '{
        drive:   '{default: DRIVE_MIN},
        slew:    '1,
        schmitt: '1,
        gpio_pu: '0,
        gpio_pd: 'h3f
    };

    // --------------------
    // Reset sequencing

    localparam int RST_HOLD_CYCLES = 16;
    localparam int RST_HOLD_W      = $clog2(RST_HOLD_CYCLES + 1);
    localparam int RST_SYNC_STAGES = 3;

endpackage

`default_nettype wire

// File: pad_core.f
pad_cfg_pkg.sv
apb_pkg.sv
reset_ctrl.sv
gpio_sync.sv
pad_regs.sv
pad_core.sv
tb_pad_core.sv

// File: pad_core.sv
// Everything runs on clk and APB accesses are legal only while enable_fixed_outputs is high
`timescale 1ns/1ps
`default_nettype none

module pad_core (
    input  logic                           clk,
    input  logic                           rst_n,

    // Register access
    input  apb_pkg::apb_req_t              apb_req,
    output apb_pkg::apb_rsp_t              apb_rsp,

    // GPIO pads
    input  logic [pad_cfg_pkg::N_GPIO-1:0] padin_gpio,
    output logic [pad_cfg_pkg::N_GPIO-1:0] padout_gpio,
    output logic [pad_cfg_pkg::N_GPIO-1:0] padoe_gpio,

    // Pad attributes and output-only pad enable
    output pad_cfg_pkg::pad_attr_t         pad_attr,
    output logic                           enable_fixed_outputs
);

    import pad_cfg_pkg::*;

    logic              rst_n_sys;
    logic              soft_rst_req;
    logic [N_GPIO-1:0] edge_clr;
    logic [N_GPIO-1:0] gpio_level;
    logic [N_GPIO-1:0] gpio_edge;

    // --------------------
    // System reset

    reset_ctrl reset_ctrl_u (
        .clk                  (clk),
        .rst_n                (rst_n),
        .soft_rst_req         (soft_rst_req),
        .rst_n_sys            (rst_n_sys),
        .enable_fixed_outputs (enable_fixed_outputs)
    );

    // --------------------
    // Registers and GPIO

    pad_regs pad_regs_u (
        .clk          (clk),
        .rst_n        (rst_n_sys),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .gpio_level   (gpio_level),
        .gpio_edge    (gpio_edge),
        .edge_clr     (edge_clr),
        .soft_rst_req (soft_rst_req),
        .pad_attr     (pad_attr),
        .padout_gpio  (padout_gpio),
        .padoe_gpio   (padoe_gpio)
    );

    gpio_sync gpio_sync_u (
        .clk        (clk),
        .rst_n      (rst_n_sys),
        .padin_gpio (padin_gpio),
        .edge_clr   (edge_clr),
        .gpio_level (gpio_level),
        .gpio_edge  (gpio_edge)
    );

endmodule

`default_nettype wire

// File: pad_regs.sv
// Zero wait state APB slave with full word writes and no byte strobes or protection checks
`timescale 1ns/1ps
`default_nettype none

module pad_regs (
    input  logic                           clk,
    input  logic                           rst_n,

    // APB slave port
    input  apb_pkg::apb_req_t              apb_req,
    output apb_pkg::apb_rsp_t              apb_rsp,

    // GPIO input logic
    input  logic [pad_cfg_pkg::N_GPIO-1:0] gpio_level,
    input  logic [pad_cfg_pkg::N_GPIO-1:0] gpio_edge,
    output logic [pad_cfg_pkg::N_GPIO-1:0] edge_clr,

    // Reset request
    output logic                           soft_rst_req,

    // Pad controls
    output pad_cfg_pkg::pad_attr_t         pad_attr,
    output logic [pad_cfg_pkg::N_GPIO-1:0] padout_gpio,
    output logic [pad_cfg_pkg::N_GPIO-1:0] padoe_gpio
);

    import apb_pkg::*;
    import pad_cfg_pkg::*;

    reg_addr_e         addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              access;
    logic              addr_ok;
    logic              bus_err;
    logic              wr_en;

    pad_attr_t         pad_attr_q;
    logic [N_GPIO-1:0] gpio_out_q;
    logic [N_GPIO-1:0] gpio_oe_q;

    // --------------------
    // Access decode

    assign addr   = reg_addr_e'(apb_req.paddr);
    assign wdata  = apb_req.pwdata;
    assign access = apb_req.psel & apb_req.penable;

    // Read mux, also flags addresses outside the map
    always_comb begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (addr)
            PAD_DRIVE: begin
                rdata[REG_DRIVE_W-1:0] = pad_attr_q.drive;
            end
            PAD_SLEW: begin
                rdata[REG_SLEW_W-1:0] = pad_attr_q.slew;
            end
            PAD_SCHMITT: begin
                rdata[REG_SCHMITT_W-1:0] = pad_attr_q.schmitt;
            end
            GPIO_OUT: begin
                rdata[REG_GPIO_W-1:0] = gpio_out_q;
            end
            GPIO_OE: begin
                rdata[REG_GPIO_W-1:0] = gpio_oe_q;
            end
            GPIO_PU: begin
                rdata[REG_GPIO_W-1:0] = pad_attr_q.gpio_pu;
            end
            GPIO_PD: begin
                rdata[REG_GPIO_W-1:0] = pad_attr_q.gpio_pd;
            end
            GPIO_IN: begin
                rdata[REG_GPIO_W-1:0] = gpio_level;
            end
            GPIO_EDGE: begin
                rdata[REG_GPIO_W-1:0] = gpio_edge;
            end
            SYS_CTRL: begin
                // Request bit is write only
                rdata = '0;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    // Errored accesses must not touch any state
    assign bus_err = access & (~addr_ok | (apb_req.pwrite & (addr == GPIO_IN)));
    assign wr_en   = access & apb_req.pwrite & ~bus_err;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = bus_err;

    // --------------------
    // Control registers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pad_attr_q <= PAD_ATTR_RESET;
            gpio_out_q <= '0;
            gpio_oe_q  <= '0;
        end else if (wr_en) begin
            case (addr)
                PAD_DRIVE: begin
                    for (int g = 0; g < N_PAD_GROUPS; g++) begin
                        pad_attr_q.drive[g] <= drive_e'(wdata[2*g +: 2]);
                    end
                end
                PAD_SLEW: begin
                    pad_attr_q.slew <= wdata[REG_SLEW_W-1:0];
                end
                PAD_SCHMITT: begin
                    pad_attr_q.schmitt <= wdata[REG_SCHMITT_W-1:0];
                end
                GPIO_OUT: begin
                    gpio_out_q <= wdata[REG_GPIO_W-1:0];
                end
                GPIO_OE: begin
                    gpio_oe_q <= wdata[REG_GPIO_W-1:0];
                end
                GPIO_PU: begin
                    pad_attr_q.gpio_pu <= wdata[REG_GPIO_W-1:0];
                end
                GPIO_PD: begin
                    pad_attr_q.gpio_pd <= wdata[REG_GPIO_W-1:0];
                end
                default: begin
                    // GPIO_EDGE and SYS_CTRL act through strobes below
                end
            endcase
        end
    end

    // --------------------
    // Write strobes

    // Both are single-cycle pulses in the access phase
    assign edge_clr     = (wr_en && addr == GPIO_EDGE) ? wdata[N_GPIO-1:0] : '0;
    assign soft_rst_req = wr_en && (addr == SYS_CTRL) && wdata[0];

    assign pad_attr    = pad_attr_q;
    assign padout_gpio = gpio_out_q;
    assign padoe_gpio  = gpio_oe_q;

endmodule

`default_nettype wire

// File: reset_ctrl.sv
// One clock domain only and soft reset requests are ignored while rst_n is held low
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic soft_rst_req,
    output logic rst_n_sys,
    output logic enable_fixed_outputs
);

    import pad_cfg_pkg::*;

    logic [RST_HOLD_W-1:0]      hold_cnt;
    logic                       hold_q;
    logic                       rst_n_hold;
    logic [RST_SYNC_STAGES-1:0] sync_q;

    // --------------------
    // Soft reset stretch

    // hold_q is high for exactly RST_HOLD_CYCLES cycles after a request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= '0;
            hold_q   <= 1'b0;
        end else if (soft_rst_req) begin
            hold_cnt <= RST_HOLD_W'(RST_HOLD_CYCLES);
            hold_q   <= 1'b1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
            hold_q   <= (hold_cnt != RST_HOLD_W'(1));
        end
    end

    // Both terms come straight from a pad or a flop, so no glitches here
    assign rst_n_hold = rst_n & ~hold_q;

    // --------------------
    // Release synchronizer

    // Asserts asynchronously, releases after RST_SYNC_STAGES edges
    always_ff @(posedge clk or negedge rst_n_hold) begin
        if (!rst_n_hold) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_n_sys = sync_q[RST_SYNC_STAGES-1];

    // Output-only pads turn on one edge after the system leaves reset
    always_ff @(posedge clk or negedge rst_n_hold) begin
        if (!rst_n_hold) begin
            enable_fixed_outputs <= 1'b0;
        end else begin
            enable_fixed_outputs <= rst_n_sys;
        end
    end

endmodule

`default_nettype wire

// File: tb_pad_core.sv
// Single clock testbench and GPIO pins only change between APB accesses, never during one
`timescale 1ns/1ps
`default_nettype none

module tb_pad_core;

    import apb_pkg::*;
    import pad_cfg_pkg::*;

    localparam int READY_TIMEOUT  = 16;
    localparam int ENABLE_TIMEOUT = 100;
    localparam int SYNC_CYCLES    = 4;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_PINS, OP_WAIT} op_e;

    typedef struct packed {
        op_e         op;
        logic [7:0]  addr;
        logic [31:0] wdata;    // write data, or pin values for OP_PINS
        logic [31:0] rdata;
        logic        err;
    } step_t;

    logic              clk = 1'b0;
    logic              rst_n;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    logic [N_GPIO-1:0] padin_gpio;
    logic [N_GPIO-1:0] padout_gpio;
    logic [N_GPIO-1:0] padoe_gpio;
    pad_attr_t         pad_attr;
    logic              enable_fixed_outputs;

    step_t             steps[$];
    integer            seed;
    int                errors;
    int                checks;

    // Expected pad state packed as drive[46:27] slew[26:17] schmitt[16:14] pu[13:7] pd[6:0]
    logic [46:0]       exp_attr;
    logic [N_GPIO-1:0] exp_out;
    logic [N_GPIO-1:0] exp_oe;
    logic              exp_en;

    pad_core DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .apb_req              (apb_req),
        .apb_rsp              (apb_rsp),
        .padin_gpio           (padin_gpio),
        .padout_gpio          (padout_gpio),
        .padoe_gpio           (padoe_gpio),
        .pad_attr             (pad_attr),
        .enable_fixed_outputs (enable_fixed_outputs)
    );

    always #5 clk = ~clk;

    // --------------------
    // Checking helpers

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s got 0x%0h expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout, %s", why);
        $display("Test failed");
        $finish;
    endtask

    task automatic reset_model();
        exp_attr = {20'h00000, 10'h3ff, 3'b111, 7'h00, 7'h3f};
        exp_out  = '0;
        exp_oe   = '0;
    endtask

    // Register writes as seen on the pads
    task automatic update_model(input logic [7:0] addr, input logic [31:0] data);
        case (addr)
            PAD_DRIVE:   exp_attr[46:27] = data[19:0];
            PAD_SLEW:    exp_attr[26:17] = data[9:0];
            PAD_SCHMITT: exp_attr[16:14] = data[2:0];
            GPIO_OUT:    exp_out = data[6:0];
            GPIO_OE:     exp_oe = data[6:0];
            GPIO_PU:     exp_attr[13:7] = data[6:0];
            GPIO_PD:     exp_attr[6:0] = data[6:0];
            SYS_CTRL: begin
                if (data[0]) begin
                    reset_model();
                    exp_en = 1'b0;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_outputs();
        check("pad_attr", pad_attr, exp_attr);
        check("padout_gpio", padout_gpio, exp_out);
        check("padoe_gpio", padoe_gpio, exp_oe);
        check("enable_fixed_outputs", enable_fixed_outputs, exp_en);
    endtask

    // --------------------
    // APB and wait tasks

    // Returns at the edge that completes the access
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int cycles;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        cycles = 0;
        while (!apb_rsp.pready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!apb_rsp.pready) begin
            abort_run("pready never came high in the APB access phase");
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_enable();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!enable_fixed_outputs && cycles < ENABLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!enable_fixed_outputs) begin
            abort_run("enable_fixed_outputs did not rise after reset");
        end
    endtask

    // --------------------
    // Stimulus table

    function automatic void add_step(input op_e op, input logic [7:0] addr,
                                     input logic [31:0] wdata, input logic [31:0] rdata,
                                     input logic err);
        steps.push_back('{op: op, addr: addr, wdata: wdata, rdata: rdata, err: err});
    endfunction

    task automatic build_table();
        logic [6:0] v1;
        logic [6:0] v2;
        logic [6:0] e;
        seed = 32'h8b1b;
        v1   = 7'($random(seed));
        v2   = 7'($random(seed));
        // Reset defaults
        add_step(OP_READ, PAD_DRIVE, 0, 32'h0, 0);
        add_step(OP_READ, PAD_SLEW, 0, 32'h3ff, 0);
        add_step(OP_READ, PAD_SCHMITT, 0, 32'h7, 0);
        add_step(OP_READ, GPIO_OUT, 0, 32'h0, 0);
        add_step(OP_READ, GPIO_OE, 0, 32'h0, 0);
        add_step(OP_READ, GPIO_PU, 0, 32'h0, 0);
        add_step(OP_READ, GPIO_PD, 0, 32'h3f, 0);
        add_step(OP_READ, SYS_CTRL, 0, 32'h0, 0);
        // Pad attributes read back masked to width
        add_step(OP_WRITE, PAD_DRIVE, 32'ha5a5_1b2c, 0, 0);
        add_step(OP_READ, PAD_DRIVE, 0, 32'h51b2c, 0);
        add_step(OP_WRITE, PAD_SLEW, 32'hffff_fc15, 0, 0);
        add_step(OP_READ, PAD_SLEW, 0, 32'h015, 0);
        add_step(OP_WRITE, PAD_SCHMITT, 32'hffff_fffa, 0, 0);
        add_step(OP_READ, PAD_SCHMITT, 0, 32'h2, 0);
        add_step(OP_WRITE, GPIO_PU, 32'h0000_00d5, 0, 0);
        add_step(OP_READ, GPIO_PU, 0, 32'h55, 0);
        add_step(OP_WRITE, GPIO_PD, 32'hffff_ff2a, 0, 0);
        add_step(OP_READ, GPIO_PD, 0, 32'h2a, 0);
        // GPIO outputs
        add_step(OP_WRITE, GPIO_OUT, 32'h0000_0093, 0, 0);
        add_step(OP_READ, GPIO_OUT, 0, 32'h13, 0);
        add_step(OP_WRITE, GPIO_OE, 32'hffff_ff6c, 0, 0);
        add_step(OP_READ, GPIO_OE, 0, 32'h6c, 0);
        // Bus errors leave everything as it was
        add_step(OP_WRITE, 8'h40, 32'hffff_ffff, 0, 1);
        add_step(OP_READ, 8'h28, 0, 32'h0, 1);
        add_step(OP_WRITE, GPIO_IN, 32'h0000_007f, 0, 1);
        add_step(OP_READ, PAD_DRIVE, 0, 32'h51b2c, 0);
        add_step(OP_READ, GPIO_OUT, 0, 32'h13, 0);
        // GPIO inputs, rising edges and write 1 to clear
        add_step(OP_PINS, 0, 32'h0, 0, 0);
        add_step(OP_READ, GPIO_EDGE, 0, 32'h0, 0);
        add_step(OP_PINS, 0, 32'(v1), 0, 0);
        add_step(OP_READ, GPIO_IN, 0, 32'(v1), 0);
        e = v1;
        add_step(OP_READ, GPIO_EDGE, 0, 32'(e), 0);
        add_step(OP_PINS, 0, 32'(v2), 0, 0);
        add_step(OP_READ, GPIO_IN, 0, 32'(v2), 0);
        e = e | (v2 & ~v1);
        add_step(OP_READ, GPIO_EDGE, 0, 32'(e), 0);
        add_step(OP_WRITE, GPIO_EDGE, 32'(e & 7'h55), 0, 0);
        e = e & ~7'h55;
        add_step(OP_READ, GPIO_EDGE, 0, 32'(e), 0);
        add_step(OP_WRITE, GPIO_EDGE, 32'h7f, 0, 0);
        add_step(OP_READ, GPIO_EDGE, 0, 32'h0, 0);
        // Rising edges on every pin for the soft reset to clear
        add_step(OP_PINS, 0, 32'h0, 0, 0);
        add_step(OP_PINS, 0, 32'h7f, 0, 0);
        add_step(OP_READ, GPIO_EDGE, 0, 32'h7f, 0);
        // Soft reset brings back the defaults
        add_step(OP_WRITE, SYS_CTRL, 32'h1, 0, 0);
        add_step(OP_WAIT, 0, 0, 0, 0);
        add_step(OP_READ, PAD_DRIVE, 0, 32'h0, 0);
        add_step(OP_READ, PAD_SLEW, 0, 32'h3ff, 0);
        add_step(OP_READ, PAD_SCHMITT, 0, 32'h7, 0);
        add_step(OP_READ, GPIO_OUT, 0, 32'h0, 0);
        add_step(OP_READ, GPIO_OE, 0, 32'h0, 0);
        add_step(OP_READ, GPIO_PU, 0, 32'h0, 0);
        add_step(OP_READ, GPIO_PD, 0, 32'h3f, 0);
        add_step(OP_READ, GPIO_EDGE, 0, 32'h0, 0);
    endtask

    // Every step ends on a falling edge where the pad outputs are checked
    task automatic apply_step(input step_t s);
        logic [31:0] rdata;
        logic        err;
        case (s.op)
            OP_WRITE: begin
                apb_write(s.addr, s.wdata, err);
                check($sformatf("pslverr on write 0x%02h", s.addr), err, s.err);
                if (!s.err) begin
                    update_model(s.addr, s.wdata);
                end
                @(negedge clk);
            end
            OP_READ: begin
                apb_read(s.addr, rdata, err);
                check($sformatf("pslverr on read 0x%02h", s.addr), err, s.err);
                check($sformatf("prdata on read 0x%02h", s.addr), rdata, s.rdata);
                @(negedge clk);
            end
            OP_PINS: begin
                @(posedge clk);
                padin_gpio <= s.wdata[N_GPIO-1:0];
                repeat (SYNC_CYCLES) @(posedge clk);
                @(negedge clk);
            end
            default: begin
                wait_enable();
                exp_en = 1'b1;
            end
        endcase
        check_outputs();
    endtask

    // --------------------
    // Main sequence

    initial begin
        rst_n      = 1'b0;
        apb_req    = '0;
        padin_gpio = '0;
        errors     = 0;
        checks     = 0;
        exp_en     = 1'b1;
        reset_model();
        build_table();
        repeat (7) @(posedge clk);
        @(negedge clk);
        check("enable_fixed_outputs in reset", enable_fixed_outputs, 1'b0);
        @(posedge clk);
        rst_n <= 1'b1;
        wait_enable();
        check_outputs();
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
